/* Makefile */
TOOL       = verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
TOP        = stq_tb
FLIST      = src.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(TOOL) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -- "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/stq_data_array.sv */
// Store queue data array
// Holds one data word per entry, written by the data update port, with a
// registered forwarding read and a combinational read for writeback

`include "stq_defines.svh"

module stq_data_array (
  input  logic               clk,
  input  logic               reset,
  input  logic               st_data_en,
  input  stq_pkg::stq_idx_t  st_data_idx,
  input  stq_pkg::stq_data_t st_data,
  input  stq_pkg::stq_idx_t  head,
  output stq_pkg::stq_data_t fwd_data,
  output stq_pkg::stq_data_t wb_data,
  stq_lookup_if.read         lk
);
  import stq_pkg::*;

  stq_data_t mem [`STQ_DEPTH];

  always_ff @(posedge clk) begin
    if (st_data_en) begin
      mem[st_data_idx] <= st_data;
    end
  end

  // Old word is read when an update hits the same entry
  always_ff @(posedge clk) begin
    if (reset) begin
      fwd_data <= '0;
    end else begin
      fwd_data <= mem[lk.sel_idx];
    end
  end

  assign wb_data = mem[head];  // Head word for the data cache

endmodule

/* design/stq_entry_array.sv */
// Store queue entry array
// Per-entry address, byte enable and status bits, kept as a ring between the
// head, commit and tail pointers. Handles allocation, commit, flush on an
// exception and drain to the data cache, and builds the load match vectors

`include "stq_defines.svh"

module stq_entry_array (
  input  logic              clk,
  input  logic              reset,
  input  logic              excpt,
  input  logic              st_valid,
  output logic              st_ready,
  input  stq_pkg::stq_addr_t st_addr,
  input  stq_pkg::stq_be_t   st_be,
  input  logic              st_data_en,
  input  stq_pkg::stq_idx_t  st_data_idx,
  input  logic              commit_en,
  input  stq_pkg::stq_addr_t ld_addr,
  input  stq_pkg::stq_be_t   ld_be,
  output logic              wb_valid,
  input  logic              wb_ready,
  output stq_pkg::stq_addr_t wb_addr,
  output stq_pkg::stq_be_t   wb_be,
  output stq_pkg::stq_idx_t  head,
  stq_lookup_if.array       lk
);
  import stq_pkg::*;

  stq_addr_t addr_q [`STQ_DEPTH];
  stq_be_t   be_q [`STQ_DEPTH];

  stq_vec_t vld;
  stq_vec_t cbit;  // Committed, waiting to drain
  stq_vec_t dpres;  // Data present

  stq_idx_t cmt_ptr;  // Oldest uncommitted entry
  stq_idx_t tail;
  logic [`STQ_IDX_W:0] count;

  logic do_alloc;
  logic do_commit;
  logic do_drain;
  logic full;
  logic unc_full;
  logic [`STQ_IDX_W:0] unc_cnt;
  logic [`STQ_IDX_W:0] flushed;
  stq_idx_t cmt_next;

  stq_vec_t alloc_oh;
  stq_vec_t commit_oh;
  stq_vec_t drain_oh;
  stq_vec_t upd_oh;
  stq_vec_t flush_vec;

  assign full     = count == (`STQ_IDX_W+1)'(`STQ_DEPTH);
  assign st_ready = !full && !excpt;
  assign do_alloc = st_valid && st_ready;

  assign do_commit = commit_en && vld[cmt_ptr] && !cbit[cmt_ptr];
  assign cmt_next  = cmt_ptr + stq_idx_t'(do_commit);

  assign wb_valid = vld[head] && cbit[head] && dpres[head];
  assign wb_addr  = addr_q[head];
  assign wb_be    = be_q[head];
  assign do_drain = wb_valid && wb_ready;

  // Pointers alone cannot tell 16 uncommitted from none
  assign unc_full = (tail == cmt_ptr) && vld[cmt_ptr] && !cbit[cmt_ptr];
  assign unc_cnt  = unc_full ? (`STQ_IDX_W+1)'(`STQ_DEPTH) : {1'b0, tail - cmt_ptr};
  assign flushed  = excpt ? unc_cnt - (`STQ_IDX_W+1)'(do_commit) : '0;

  assign alloc_oh  = stq_vec_t'(do_alloc) << tail;
  assign commit_oh = stq_vec_t'(do_commit) << cmt_ptr;
  assign drain_oh  = stq_vec_t'(do_drain) << head;
  assign upd_oh    = stq_vec_t'(st_data_en) << st_data_idx;
  assign flush_vec = excpt ? (vld & ~cbit & ~commit_oh) : '0;  // Just committed entry survives

  always_ff @(posedge clk) begin
    if (reset) begin
      vld     <= '0;
      cbit    <= '0;
      dpres   <= '0;
      head    <= '0;
      cmt_ptr <= '0;
      tail    <= '0;
      count   <= '0;
    end else begin
      vld     <= (vld & ~drain_oh & ~flush_vec) | alloc_oh;
      cbit    <= (cbit | commit_oh) & ~drain_oh & ~alloc_oh;
      dpres   <= (dpres | (upd_oh & vld)) & ~drain_oh & ~alloc_oh;  // Ignore invalid slots
      head    <= head + stq_idx_t'(do_drain);
      cmt_ptr <= cmt_next;
      tail    <= excpt ? cmt_next : tail + stq_idx_t'(do_alloc);
      count   <= count + (`STQ_IDX_W+1)'(do_alloc) - (`STQ_IDX_W+1)'(do_drain) - flushed;
    end
  end

  always_ff @(posedge clk) begin
    if (do_alloc) begin
      addr_q[tail] <= st_addr;
      be_q[tail]   <= st_be;
    end
  end

  // Match vectors for the load, from state before this edge
  always_comb begin
    for (int i = 0; i < `STQ_DEPTH; i++) begin
      lk.ovl_vec[i]   = vld[i] && (addr_q[i] == ld_addr) && |(be_q[i] & ld_be);
      lk.cover_vec[i] = dpres[i] && ((be_q[i] & ld_be) == ld_be);
    end
  end

  assign lk.tail = tail;

endmodule

/* design/stq_fwd_pick.sv */
// Store queue forwarding picker
// Finds the youngest store that overlaps the load and registers the hit or
// conflict result one cycle after the lookup

`include "stq_defines.svh"

module stq_fwd_pick (
  input  logic       clk,
  input  logic       reset,
  input  logic       ld_en,
  output logic       fwd_valid,
  output logic       fwd_hit,
  output logic       fwd_conflict,
  stq_lookup_if.pick lk
);
  import stq_pkg::*;

  stq_vec_t rot;  // Bit j is entry tail+j, youngest on top
  stq_idx_t sel_off;
  logic     found;
  logic     sel_cover;

  always_comb begin
    for (int j = 0; j < `STQ_DEPTH; j++) begin
      rot[j] = lk.ovl_vec[lk.tail + stq_idx_t'(j)];
    end
  end

  // Last set bit of the rotated vector
  always_comb begin
    found   = 1'b0;
    sel_off = '0;
    for (int j = 0; j < `STQ_DEPTH; j++) begin
      if (rot[j]) begin
        found   = 1'b1;
        sel_off = stq_idx_t'(j);
      end
    end
  end

  assign lk.sel_idx   = lk.tail + sel_off;
  assign lk.sel_found = found;
  assign sel_cover    = lk.cover_vec[lk.sel_idx];

  always_ff @(posedge clk) begin
    if (reset) begin
      fwd_valid    <= 1'b0;
      fwd_hit      <= 1'b0;
      fwd_conflict <= 1'b0;
    end else begin
      fwd_valid    <= ld_en;
      fwd_hit      <= ld_en && lk.sel_found && sel_cover;
      fwd_conflict <= ld_en && lk.sel_found && !sel_cover;  // Partial cover or no data yet
    end
  end

endmodule

/* design/stq_lookup_if.sv */
// Store queue forwarding lookup
// Carries the per-entry match vectors of a load from the entry array to the
// match picker, and the picked entry index on to the data array

interface stq_lookup_if;

  stq_pkg::stq_vec_t ovl_vec;  // Same address with overlapping bytes
  stq_pkg::stq_vec_t cover_vec;  // Covers all load bytes, data present
  stq_pkg::stq_idx_t tail;  // Next free slot, youngest is tail-1

  stq_pkg::stq_idx_t sel_idx;  // Youngest overlapping entry
  logic sel_found;

  modport array (
    output ovl_vec,
    output cover_vec,
    output tail
  );

  modport pick (
    input  ovl_vec,
    input  cover_vec,
    input  tail,
    output sel_idx,
    output sel_found
  );

  modport read (
    input sel_idx
  );

endinterface

/* design/stq_pkg.sv */
// Store queue types
// Vector typedefs shared by the store queue blocks

`include "stq_defines.svh"

package stq_pkg;

  // Queue entry index, wraps with the ring pointers
  typedef logic [`STQ_IDX_W-1:0] stq_idx_t;

  typedef logic [`STQ_ADDR_W-1:0] stq_addr_t;  // Word address

  typedef logic [`STQ_DATA_W-1:0] stq_data_t;  // Store data word

  typedef logic [`STQ_BE_W-1:0] stq_be_t;  // Byte enable

  // One bit per queue entry
  typedef logic [`STQ_DEPTH-1:0] stq_vec_t;

endpackage

/* design/stq_top.sv */
// Store queue top level
// Keeps stores in program order from allocation to data cache writeback,
// forwards store data to loads and flushes uncommitted stores on an exception

module stq_top (
  input  logic               clk,
  input  logic               reset,
  input  logic               excpt,
  input  logic               st_valid,
  output logic               st_ready,
  input  stq_pkg::stq_addr_t st_addr,
  input  stq_pkg::stq_be_t   st_be,
  input  logic               st_data_en,
  input  stq_pkg::stq_idx_t  st_data_idx,
  input  stq_pkg::stq_data_t st_data,
  input  logic               commit_en,
  input  logic               ld_en,
  input  stq_pkg::stq_addr_t ld_addr,
  input  stq_pkg::stq_be_t   ld_be,
  output logic               fwd_valid,
  output logic               fwd_hit,
  output logic               fwd_conflict,
  output stq_pkg::stq_data_t fwd_data,
  output logic               wb_valid,
  input  logic               wb_ready,
  output stq_pkg::stq_addr_t wb_addr,
  output stq_pkg::stq_be_t   wb_be,
  output stq_pkg::stq_data_t wb_data
);
  import stq_pkg::*;

  stq_idx_t head;  // Entry being drained

  stq_lookup_if lk ();

  stq_entry_array u_entry (
    .clk         (clk),
    .reset       (reset),
    .excpt       (excpt),
    .st_valid    (st_valid),
    .st_ready    (st_ready),
    .st_addr     (st_addr),
    .st_be       (st_be),
    .st_data_en  (st_data_en),
    .st_data_idx (st_data_idx),
    .commit_en   (commit_en),
    .ld_addr     (ld_addr),
    .ld_be       (ld_be),
    .wb_valid    (wb_valid),
    .wb_ready    (wb_ready),
    .wb_addr     (wb_addr),
    .wb_be       (wb_be),
    .head        (head),
    .lk          (lk.array)
  );

  stq_fwd_pick u_pick (
    .clk          (clk),
    .reset        (reset),
    .ld_en        (ld_en),
    .fwd_valid    (fwd_valid),
    .fwd_hit      (fwd_hit),
    .fwd_conflict (fwd_conflict),
    .lk           (lk.pick)
  );

  stq_data_array u_data (
    .clk         (clk),
    .reset       (reset),
    .st_data_en  (st_data_en),
    .st_data_idx (st_data_idx),
    .st_data     (st_data),
    .head        (head),
    .fwd_data    (fwd_data),
    .wb_data     (wb_data),
    .lk          (lk.read)
  );

endmodule

/* include/stq_defines.svh */
// Store queue sizing
// Queue depth and the widths of the index, address, data and byte-enable fields

`ifndef STQ_DEFINES_SVH
`define STQ_DEFINES_SVH

// Number of queue entries
`define STQ_DEPTH 16

// Entry index, must cover STQ_DEPTH
`define STQ_IDX_W 4

// Word address, byte offset dropped
`define STQ_ADDR_W 30

// One store data word
`define STQ_DATA_W 32

// One enable bit per data byte
`define STQ_BE_W 4

`endif

/* src.f */
+incdir+include
design/stq_pkg.sv
design/stq_lookup_if.sv
design/stq_entry_array.sv
design/stq_fwd_pick.sv
design/stq_data_array.sv
design/stq_top.sv
verif/stq_assert.sv
verif/stq_tb.sv

/* verif/stq_assert.sv */
// Store queue protocol checks
// Writeback hold under back-pressure, forwarding flag consistency and the
// allocation stall of a full queue, bound into the store queue top level

`include "stq_defines.svh"

module stq_assert (
  input logic                clk,
  input logic                reset,
  input logic                st_ready,
  input logic                fwd_valid,
  input logic                fwd_hit,
  input logic                fwd_conflict,
  input logic                wb_valid,
  input logic                wb_ready,
  input stq_pkg::stq_addr_t  wb_addr,
  input stq_pkg::stq_be_t    wb_be,
  input stq_pkg::stq_data_t  wb_data,
  input stq_pkg::stq_vec_t   valid_vec
);

  wb_hold: assert property (@(posedge clk) disable iff (reset)
    wb_valid && !wb_ready |=>
      wb_valid && $stable(wb_addr) && $stable(wb_be) && $stable(wb_data))
    else $error("Writeback store changed while the data cache stalled");

  fwd_excl: assert property (@(posedge clk) disable iff (reset) !(fwd_hit && fwd_conflict))
    else $error("Forward hit and conflict raised together");

  fwd_hit_vld: assert property (@(posedge clk) disable iff (reset) fwd_hit |-> fwd_valid)
    else $error("Forward hit without a valid lookup result");

  full_stall: assert property (@(posedge clk) disable iff (reset)
    $countones(valid_vec) == `STQ_DEPTH |-> !st_ready)
    else $error("Allocation ready with every entry in use");

endmodule

bind stq_top stq_assert u_assert (
  .clk          (clk),
  .reset        (reset),
  .st_ready     (st_ready),
  .fwd_valid    (fwd_valid),
  .fwd_hit      (fwd_hit),
  .fwd_conflict (fwd_conflict),
  .wb_valid     (wb_valid),
  .wb_ready     (wb_ready),
  .wb_addr      (wb_addr),
  .wb_be        (wb_be),
  .wb_data      (wb_data),
  .valid_vec    (u_entry.vld)
);

/* verif/stq_tb.sv */
// Store queue testbench
// Drives allocation, data update, commit, flush, load lookup and writeback,
// and checks the outputs against a program-order model of the queue

`include "stq_defines.svh"

module stq_tb;
  import stq_pkg::*;

  localparam int T_BASIC = 60;
  localparam int T_FWD   = 60;
  localparam int T_FULL  = 90;
  localparam int T_FLUSH = 70;
  localparam int T_HOLD  = 40;
  localparam int WATCHDOG_TIME = (T_BASIC + T_FWD + T_FULL + T_FLUSH + T_HOLD + 50) * 20;

  typedef struct packed {
    stq_addr_t addr;
    stq_be_t   be;
    stq_data_t data;
    logic      dp;  // Data present
    logic      cmt;
    stq_idx_t  slot;
  } ent_t;

  logic      clk, reset, excpt;
  logic      st_valid, st_ready, st_data_en, commit_en, ld_en, wb_valid, wb_ready;
  logic      fwd_valid, fwd_hit, fwd_conflict;
  stq_addr_t st_addr, ld_addr, wb_addr;
  stq_be_t   st_be, ld_be, wb_be;
  stq_idx_t  st_data_idx;
  stq_data_t st_data, fwd_data, wb_data;

  ent_t      mq[$];  // Oldest store at the front
  stq_idx_t  m_tail;
  int        m_cnt;
  logic      exp_fwd_valid, exp_fwd_hit, exp_fwd_conflict, exp_wb_valid;
  stq_data_t exp_fwd_data, exp_wb_data;
  stq_addr_t exp_wb_addr;
  stq_be_t   exp_wb_be;
  int        err_cnt;
  int        chk_err;
  int        n_tests;

  stq_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("Timeout: the tests did not finish within %0d time units", WATCHDOG_TIME);
    $display("=== FAIL ===");
    $finish;
  end

  always @(posedge clk) begin
    ent_t e;
    int   cidx;
    logic found;
    logic drain;
    logic alloc_ok;
    if (reset) begin
      mq.delete();
      m_tail = '0;
      m_cnt <= 0;
      exp_fwd_valid <= 1'b0;
      exp_fwd_hit <= 1'b0;
      exp_fwd_conflict <= 1'b0;
      exp_wb_valid <= 1'b0;
    end else begin
      found = 1'b0;
      exp_fwd_valid <= ld_en;
      exp_fwd_hit <= 1'b0;
      exp_fwd_conflict <= 1'b0;
      for (int i = mq.size() - 1; i >= 0; i--) begin  // Youngest first
        if (ld_en && !found && mq[i].addr == ld_addr && (mq[i].be & ld_be) != '0) begin
          found = 1'b1;
          if ((mq[i].be & ld_be) == ld_be && mq[i].dp) begin
            exp_fwd_hit <= 1'b1;
            exp_fwd_data <= mq[i].data;
          end else begin
            exp_fwd_conflict <= 1'b1;
          end
        end
      end
      drain = mq.size() > 0 && mq[0].cmt && mq[0].dp && wb_ready;
      alloc_ok = st_valid && mq.size() < `STQ_DEPTH && !excpt;
      cidx = -1;
      for (int i = 0; i < mq.size(); i++) begin
        e = mq[i];
        if (st_data_en && e.slot == st_data_idx) begin
          e.dp = 1'b1;
          e.data = st_data;
          mq[i] = e;
        end
        if (cidx < 0 && !e.cmt) cidx = i;
      end
      if (commit_en && cidx >= 0) begin
        e = mq[cidx];
        e.cmt = 1'b1;
        mq[cidx] = e;
      end
      while (excpt && mq.size() > 0 && !mq[mq.size() - 1].cmt) begin
        void'(mq.pop_back());
        m_tail--;  // Tail falls back over every flushed store
      end
      if (drain) void'(mq.pop_front());
      if (alloc_ok) begin
        e = '{addr: st_addr, be: st_be, data: '0, dp: 1'b0, cmt: 1'b0, slot: m_tail};
        mq.push_back(e);
        m_tail++;
      end
      exp_wb_valid <= mq.size() > 0 && mq[0].cmt && mq[0].dp;
      if (mq.size() > 0) begin
        exp_wb_addr <= mq[0].addr;
        exp_wb_be <= mq[0].be;
        exp_wb_data <= mq[0].data;
      end
      m_cnt <= mq.size();
    end
  end

  ready_ok: assert property (@(posedge clk) disable iff (reset)
    st_ready == (m_cnt < `STQ_DEPTH && !excpt))
    else begin
      err_cnt++;
      $display("Fail at %0t: st_ready does not follow the queue occupancy", $time);
    end

  fwd_flags_ok: assert property (@(posedge clk) disable iff (reset)
    fwd_valid == exp_fwd_valid && fwd_hit == exp_fwd_hit && fwd_conflict == exp_fwd_conflict)
    else begin
      err_cnt++;
      $display("Fail at %0t: forwarding flags differ from the model", $time);
    end

  fwd_data_ok: assert property (@(posedge clk) disable iff (reset)
    fwd_hit |-> fwd_data == exp_fwd_data)
    else begin
      err_cnt++;
      $display("Fail at %0t: forwarded word is not the youngest store's", $time);
    end

  wb_valid_ok: assert property (@(posedge clk) disable iff (reset) wb_valid == exp_wb_valid)
    else begin
      err_cnt++;
      $display("Fail at %0t: wb_valid differs from the model", $time);
    end

  wb_fields_ok: assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> wb_addr == exp_wb_addr && wb_be == exp_wb_be && wb_data == exp_wb_data)
    else begin
      err_cnt++;
      $display("Fail at %0t: writeback store is out of order or corrupted", $time);
    end

  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic push_store(input stq_addr_t addr, input stq_be_t be, output stq_idx_t slot);
    int n;
    n = 0;
    while (!st_ready && n < 40) begin
      tick();
      n++;
    end
    slot = m_tail;  // Allocation takes the tail entry
    st_valid = 1'b1;
    st_addr = addr;
    st_be = be;
    tick();
    st_valid = 1'b0;
  endtask

  task automatic put_data(input stq_idx_t slot, input stq_data_t data);
    st_data_en = 1'b1;
    st_data_idx = slot;
    st_data = data;
    tick();
    st_data_en = 1'b0;
  endtask

  task automatic commit_oldest();
    commit_en = 1'b1;
    tick();
    commit_en = 1'b0;
  endtask

  task automatic load_lookup(input stq_addr_t addr, input stq_be_t be);
    ld_en = 1'b1;
    ld_addr = addr;
    ld_be = be;
    tick();
    ld_en = 1'b0;
  endtask

  task automatic drain_until_empty(input int limit);
    int n;
    n = 0;
    wb_ready = 1'b1;
    while (m_cnt != 0 && n < limit) begin
      tick();
      n++;
    end
    wb_ready = 1'b0;
    if (m_cnt != 0) begin
      chk_err++;
      $display("Drain stalled with %0d stores left after %0d cycles", m_cnt, limit);
    end
  endtask

  task automatic end_test(input string name);
    n_tests++;
    $display("Test %0d %s finished, %0d errors so far", n_tests, name, err_cnt + chk_err);
  endtask

  initial begin
    stq_idx_t  slot;
    stq_idx_t  slots [`STQ_DEPTH];
    stq_addr_t fa;
    int        n;
    void'($urandom(32'hdbf0_1ad9));
    {reset, excpt, st_valid, st_data_en, commit_en, ld_en, wb_ready} = 7'b1000000;
    st_addr = '0;
    st_be = '0;
    st_data_idx = '0;
    st_data = '0;
    ld_addr = '0;
    ld_be = '0;
    err_cnt = 0;
    chk_err = 0;
    n_tests = 0;
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;

    assert (st_ready && !wb_valid && !fwd_valid && !fwd_hit && !fwd_conflict)
      else begin
        chk_err++;
        $display("Fail at %0t: outputs not idle after reset", $time);
      end
    for (int i = 0; i < 4; i++) begin
      push_store(stq_addr_t'($urandom), stq_be_t'($urandom_range(15, 1)), slots[i]);
    end
    for (int i = 3; i >= 0; i--) put_data(slots[i], stq_data_t'($urandom));
    repeat (4) commit_oldest();
    drain_until_empty(20);
    end_test("allocation and drain");

    fa = 30'h0100_1a40;
    push_store(fa, 4'hf, slots[0]);
    put_data(slots[0], stq_data_t'($urandom));
    push_store(fa, 4'h3, slots[1]);
    put_data(slots[1], stq_data_t'($urandom));
    load_lookup(fa, 4'h3);
    load_lookup(fa, 4'hc);  // Skips the younger narrow store
    load_lookup(fa, 4'h6);
    push_store(fa, 4'hf, slots[2]);
    load_lookup(fa, 4'h1);  // Youngest has no data yet
    load_lookup(fa + 30'd1, 4'hf);
    put_data(slots[2], stq_data_t'($urandom));
    load_lookup(fa, 4'h1);
    repeat (3) commit_oldest();
    drain_until_empty(20);
    end_test("forwarding");

    fa = 30'h0280_0000;
    for (int i = 0; i < `STQ_DEPTH; i++) push_store(fa + stq_addr_t'(i), 4'hf, slots[i]);
    for (int i = 0; i < `STQ_DEPTH; i++) put_data(slots[i], stq_data_t'($urandom));
    st_valid = 1'b1;  // Refused while full
    st_addr = fa;
    tick();
    st_valid = 1'b0;
    commit_oldest();
    n = 0;
    while (!wb_valid && n < 10) begin
      tick();
      n++;
    end
    wb_ready = 1'b1;
    tick();
    wb_ready = 1'b0;
    tick();
    wb_ready = 1'b1;
    commit_en = 1'b1;
    repeat (`STQ_DEPTH - 1) tick();
    commit_en = 1'b0;
    drain_until_empty(30);
    end_test("full queue");

    fa = 30'h0200_0000;
    for (int i = 0; i < 3; i++) begin
      push_store(fa + stq_addr_t'(i), 4'hf, slots[i]);
      put_data(slots[i], stq_data_t'($urandom));
    end
    commit_oldest();
    push_store(fa + 30'd3, 4'hf, slots[3]);
    put_data(slots[3], stq_data_t'($urandom));
    push_store(fa + 30'd4, 4'h3, slots[4]);
    excpt = 1'b1;  // Commit and a refused allocation in the flush cycle
    commit_en = 1'b1;
    st_valid = 1'b1;
    st_addr = fa + 30'd5;
    tick();
    {excpt, commit_en, st_valid} = 3'b000;
    for (int i = 0; i < 6; i++) load_lookup(fa + stq_addr_t'(i), 4'hf);
    drain_until_empty(20);
    push_store(fa + 30'd2, 4'hf, slot);
    put_data(slot, stq_data_t'($urandom));
    load_lookup(fa + 30'd2, 4'hf);
    commit_oldest();
    drain_until_empty(20);
    end_test("exception flush");

    fa = 30'h0300_0000;
    for (int i = 0; i < 2; i++) begin
      push_store(fa + stq_addr_t'(i), 4'hf, slots[i]);
      put_data(slots[i], stq_data_t'($urandom));
    end
    repeat (2) commit_oldest();
    for (int i = 0; i < 6; i++) begin
      load_lookup(fa + stq_addr_t'(i % 2), stq_be_t'($urandom_range(15, 1)));
    end
    drain_until_empty(20);
    end_test("writeback back-pressure");

    $display("Tests run %0d, errors %0d", n_tests, err_cnt + chk_err);
    if (err_cnt + chk_err == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
